//--- adc_capture_pkg.sv
// Shared widths, depths and types for the ADC sample-capture path.
// Every RTL file pulls these in with a wildcard import in its module header.
// A buffer word carries one sample per ADC, ADC0 in the upper half.

package adc_capture_pkg;

	// one deserialized lane byte
	localparam int LANE_BITS = 8;

	// two lanes make one ADC sample
	localparam int SAMPLE_BITS = 2 * LANE_BITS;

	// ADCs captured side by side in one buffer word
	localparam int ADC_COUNT = 2;

	// capture buffer geometry
	localparam int BUF_ADDR_BITS = 10;
	localparam int BUF_DEPTH = 1 << BUF_ADDR_BITS;

	// flops in the capture enable synchronizer
	localparam int SYNC_STAGES = 3;

	typedef logic [LANE_BITS-1:0] lane_t;

	// rotation amount, 0 to LANE_BITS-1
	typedef logic [$clog2(LANE_BITS)-1:0] bitslip_t;

	typedef logic [SAMPLE_BITS-1:0] sample_t;

	typedef logic [ADC_COUNT*SAMPLE_BITS-1:0] buf_word_t;

	typedef logic [BUF_ADDR_BITS-1:0] buf_addr_t;

	// capture FSM
	typedef enum logic [1:0] {
		IDLE,
		FILL,
		DONE
	} capture_state_t;

endpackage

//--- lane_decoder.sv
// Bit alignment and sample assembly for the four deserialized ADC lanes.
// Each lane is rotated left by the shared bitslip amount, lane pairs are
// joined into 16-bit samples and the whole word is registered once.
// sample_word follows the lanes by exactly one data_clk_div cycle.

`timescale 1ns/1ps

module lane_decoder
	import adc_capture_pkg::*;
(
	input  logic      data_clk_div,
	input  logic      rst_n,
	input  lane_t     lane0,
	input  lane_t     lane1,
	input  lane_t     lane2,
	input  lane_t     lane3,
	input  bitslip_t  bitslip,
	output buf_word_t sample_word
);

	// rotate left, bits leaving the top come back at the bottom
	function automatic lane_t rotl(input lane_t b, input bitslip_t n);
		logic [2*LANE_BITS-1:0] d;
		d = {b, b} << n;
		return d[2*LANE_BITS-1 -: LANE_BITS];
	endfunction

	lane_t     lanes [2*ADC_COUNT];
	sample_t   adc_sample [ADC_COUNT];
	buf_word_t word_nxt;

	assign lanes[0] = lane0;
	assign lanes[1] = lane1;
	assign lanes[2] = lane2;
	assign lanes[3] = lane3;

	// even lane is the high byte of its sample
	always_comb begin
		for (int i = 0; i < ADC_COUNT; i++) begin
			adc_sample[i] = {rotl(lanes[2*i], bitslip), rotl(lanes[2*i+1], bitslip)};
		end
	end

	// adc0 goes to the upper half
	always_comb begin
		word_nxt = '0;
		for (int i = 0; i < ADC_COUNT; i++) begin
			word_nxt[(ADC_COUNT-1-i)*SAMPLE_BITS +: SAMPLE_BITS] = adc_sample[i];
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			sample_word <= '0;
		end else begin
			sample_word <= word_nxt;
		end
	end

endmodule

//--- capture_sequencer.sv
// Capture control for one burst of BUF_DEPTH words.
// capture_enable is synchronized into data_clk_div, a rising edge starts
// a fill from address 0 and a falling edge returns to idle at any time.
// capture_busy is high while filling, capture_done once the burst is complete.

`timescale 1ns/1ps

module capture_sequencer
	import adc_capture_pkg::*;
(
	input  logic      data_clk_div,
	input  logic      rst_n,
	input  logic      capture_enable,
	output logic      wr_en,
	output buf_addr_t wr_addr,
	output logic      capture_busy,
	output logic      capture_done
);

	logic [SYNC_STAGES-1:0] en_sync;
	logic                   en_prev;
	logic                   en_rise;
	logic                   en_fall;
	capture_state_t         state;
	capture_state_t         state_nxt;

	// enable may be asynchronous to the sample clock
	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			en_sync <= '0;
			en_prev <= 1'b0;
		end else begin
			en_sync <= {en_sync[SYNC_STAGES-2:0], capture_enable};
			en_prev <= en_sync[SYNC_STAGES-1];
		end
	end

	assign en_rise = en_sync[SYNC_STAGES-1] & ~en_prev;
	assign en_fall = ~en_sync[SYNC_STAGES-1] & en_prev;

	always_comb begin
		state_nxt = state;
		unique case (state)
			IDLE: begin
				if (en_rise) begin
					state_nxt = FILL;
				end
			end
			FILL: begin
				if (en_fall) begin
					state_nxt = IDLE;
				end else if (wr_addr == buf_addr_t'(BUF_DEPTH - 1)) begin
					state_nxt = DONE;
				end
			end
			DONE: begin
				if (en_fall) begin
					state_nxt = IDLE;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			state        <= IDLE;
			wr_en        <= 1'b0;
			wr_addr      <= '0;
			capture_done <= 1'b0;
		end else begin
			state        <= state_nxt;
			wr_en        <= (state_nxt == FILL);
			capture_done <= (state_nxt == DONE);
			// address restarts at 0 on every entry into FILL
			if (state == FILL && state_nxt == FILL) begin
				wr_addr <= wr_addr + 1'b1;
			end else begin
				wr_addr <= '0;
			end
		end
	end

	assign capture_busy = (state == FILL);

	a_wr_in_fill: assert property (@(posedge data_clk_div) disable iff (!rst_n)
		wr_en |-> state == FILL);

	// consecutive writes must land on consecutive addresses
	a_addr_step: assert property (@(posedge data_clk_div) disable iff (!rst_n)
		(wr_en && $past(wr_en)) |-> wr_addr == buf_addr_t'($past(wr_addr) + 1'b1));

	a_busy_done: assert property (@(posedge data_clk_div) disable iff (!rst_n)
		!(capture_busy && capture_done));

endmodule

//--- sample_buffer.sv
// Capture memory of BUF_DEPTH buffer words.
// One synchronous write port driven by the capture sequencer and one
// registered read port: rd_en with rd_addr gives rd_data and rd_valid
// one cycle later, and a read may be issued every cycle.

`timescale 1ns/1ps

module sample_buffer
	import adc_capture_pkg::*;
(
	input  logic      data_clk_div,
	input  logic      rst_n,
	input  logic      wr_en,
	input  buf_addr_t wr_addr,
	input  buf_word_t wr_data,
	input  logic      rd_en,
	input  buf_addr_t rd_addr,
	output buf_word_t rd_data,
	output logic      rd_valid
);

	buf_word_t mem [BUF_DEPTH];

	always_ff @(posedge data_clk_div) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read returns the old word on a same-address write
	always_ff @(posedge data_clk_div) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_en;
		end
	end

	a_rd_valid_follows: assert property (@(posedge data_clk_div) disable iff (!rst_n)
		rd_valid |-> $past(rd_en && rst_n));

endmodule

//--- adc_capture_top.sv
// Top level of the ADC sample-capture path in the data_clk_div domain.
// Four aligned lanes are decoded into two-ADC words, a rising edge of
// capture_enable writes one burst into the capture buffer, and the buffer
// is read back through the rd_en / rd_addr / rd_data / rd_valid port.
// rst_n is expected to be synchronous to data_clk_div already.

`timescale 1ns/1ps

module adc_capture_top
	import adc_capture_pkg::*;
(
	input  logic      data_clk_div,
	input  logic      rst_n,
	input  lane_t     lane0,
	input  lane_t     lane1,
	input  lane_t     lane2,
	input  lane_t     lane3,
	// only change while capture_busy is low
	input  bitslip_t  bitslip,
	input  logic      capture_enable,
	input  logic      rd_en,
	input  buf_addr_t rd_addr,
	output logic      capture_busy,
	output logic      capture_done,
	output buf_word_t rd_data,
	output logic      rd_valid
);

	buf_word_t sample_word;
	logic      wr_en;
	buf_addr_t wr_addr;

	lane_decoder i_lane_decoder (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n),
		.lane0        (lane0),
		.lane1        (lane1),
		.lane2        (lane2),
		.lane3        (lane3),
		.bitslip      (bitslip),
		.sample_word  (sample_word)
	);

	capture_sequencer i_capture_sequencer (
		.data_clk_div   (data_clk_div),
		.rst_n          (rst_n),
		.capture_enable (capture_enable),
		.wr_en          (wr_en),
		.wr_addr        (wr_addr),
		.capture_busy   (capture_busy),
		.capture_done   (capture_done)
	);

	// decoded word is written straight from the decoder register
	sample_buffer i_sample_buffer (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (sample_word),
		.rd_en        (rd_en),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.rd_valid     (rd_valid)
	);

endmodule

//--- tb_clock_gen.sv
// Clock and reset source for the capture testbench.
// data_clk_div runs at a 10 ns period, rst_n is held low for the
// first 5 rising edges and released just after the fifth.

`timescale 1ns/1ps

module tb_clock_gen (
	output logic data_clk_div,
	output logic rst_n
);

	initial begin
		data_clk_div = 1'b0;
		forever #5 data_clk_div = ~data_clk_div;
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge data_clk_div);
		#1;
		rst_n = 1'b1;
	end

endmodule

//--- tb_adc_capture.sv
// Testbench for the ADC sample-capture path.
// A free-running counter feeds the four lanes, captures are started and
// stopped through capture_enable, and the buffer is read back and compared
// with a reference model of the lane decode. Inputs change 1 ns after
// each rising edge, read data is checked at the falling edge.

`timescale 1ns/1ps

module tb_adc_capture
	import adc_capture_pkg::*;
();

	logic      data_clk_div;
	logic      rst_n;
	lane_t     lane0;
	lane_t     lane1;
	lane_t     lane2;
	lane_t     lane3;
	bitslip_t  bitslip;
	logic      capture_enable;
	logic      rd_en;
	buf_addr_t rd_addr;
	logic      capture_busy;
	logic      capture_done;
	buf_word_t rd_data;
	logic      rd_valid;

	lane_t     k;
	int        errors;
	int        tests_run;
	int        tests_failed;
	int        test_err_base;
	logic      rd_pending;
	buf_word_t last_data;
	buf_word_t shadow [BUF_DEPTH];
	buf_word_t exp_q [$];
	bit        chk_q [$];
	buf_addr_t addr_q [$];

	tb_clock_gen i_tb_clock_gen (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n)
	);

	adc_capture_top i_adc_capture_top (
		.data_clk_div   (data_clk_div),
		.rst_n          (rst_n),
		.lane0          (lane0),
		.lane1          (lane1),
		.lane2          (lane2),
		.lane3          (lane3),
		.bitslip        (bitslip),
		.capture_enable (capture_enable),
		.rd_en          (rd_en),
		.rd_addr        (rd_addr),
		.capture_busy   (capture_busy),
		.capture_done   (capture_done),
		.rd_data        (rd_data),
		.rd_valid       (rd_valid)
	);

	function automatic lane_t rotate_left(input lane_t b, input bitslip_t n);
		lane_t r;
		r = b;
		for (int i = 0; i < n; i++) begin
			r = {r[LANE_BITS-2:0], r[LANE_BITS-1]};
		end
		return r;
	endfunction

	function automatic lane_t rotate_right(input lane_t b, input bitslip_t n);
		lane_t r;
		r = b;
		for (int i = 0; i < n; i++) begin
			r = {r[0], r[LANE_BITS-1:1]};
		end
		return r;
	endfunction

	// expected buffer word for counter value kv
	function automatic buf_word_t expected_word(input lane_t kv, input bitslip_t slip);
		lane_t l0;
		lane_t l1;
		lane_t l2;
		lane_t l3;
		l0 = kv;
		l1 = kv ^ 8'h5a;
		l2 = ~kv;
		l3 = kv + 8'h33;
		return {rotate_left(l0, slip), rotate_left(l1, slip),
			rotate_left(l2, slip), rotate_left(l3, slip)};
	endfunction

	function automatic logic probe(input string name);
		if (name == "capture_busy") begin
			return capture_busy;
		end else if (name == "capture_done") begin
			return capture_done;
		end
		return rst_n;
	endfunction

	// lane pattern from the free-running counter
	always @(posedge data_clk_div) begin
		#1;
		k = k + 1'b1;
		lane0 = k;
		lane1 = k ^ 8'h5a;
		lane2 = ~k;
		lane3 = k + 8'h33;
	end

	// read port compare, one read in flight
	always @(negedge data_clk_div) begin
		if (rst_n) begin
			assert (rd_valid === rd_pending) else begin
				$display("MISMATCH t=%0t rd_valid expected %b got %b", $time, rd_pending, rd_valid);
				errors++;
			end
			if (rd_valid === 1'b1 && exp_q.size() > 0) begin
				if (chk_q[0]) begin
					assert (rd_data === exp_q[0]) else begin
						$display("MISMATCH t=%0t rd_data at address %0d expected %h got %h",
							$time, addr_q[0], exp_q[0], rd_data);
						errors++;
					end
				end
				last_data = rd_data;
				void'(exp_q.pop_front());
				void'(chk_q.pop_front());
				void'(addr_q.pop_front());
			end
		end
		rd_pending = rd_en;
	end

	task automatic next_cycle();
		@(posedge data_clk_div);
		#1;
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic wait_signal(input string name, input logic level, input int limit);
		int n;
		n = 0;
		while (probe(name) !== level && n < limit) begin
			next_cycle();
			n++;
		end
		if (probe(name) !== level) begin
			$display("timeout at t=%0t: %s did not go to %b within %0d cycles",
				$time, name, level, limit);
			errors++;
		end
	endtask

	task automatic issue_read(input buf_addr_t addr, input buf_word_t exp, input bit chk);
		next_cycle();
		rd_en = 1'b1;
		rd_addr = addr;
		exp_q.push_back(exp);
		chk_q.push_back(chk);
		addr_q.push_back(addr);
	endtask

	task automatic end_reads();
		next_cycle();
		rd_en = 1'b0;
	endtask

	// every issued read must come back with rd_valid
	task automatic wait_reads();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 10) begin
			next_cycle();
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout at t=%0t: %0d reads never returned rd_valid", $time, exp_q.size());
			errors++;
			exp_q.delete();
			chk_q.delete();
			addr_q.delete();
		end
	endtask

	task automatic run_capture(input bitslip_t slip);
		next_cycle();
		bitslip = slip;
		capture_enable = 1'b1;
		wait_signal("capture_busy", 1'b1, 20);
		wait_signal("capture_done", 1'b1, BUF_DEPTH + 20);
		check_bit("capture_busy", capture_busy, 1'b0);
	endtask

	// recover k0 from word 0, then read back the whole burst
	task automatic check_buffer(input bitslip_t slip);
		lane_t k0;
		issue_read('0, '0, 1'b0);
		end_reads();
		wait_reads();
		k0 = rotate_right(last_data[4*LANE_BITS-1 -: LANE_BITS], slip);
		for (int i = 0; i < BUF_DEPTH; i++) begin
			shadow[i] = expected_word(lane_t'(k0 + i), slip);
			issue_read(buf_addr_t'(i), shadow[i], 1'b1);
		end
		end_reads();
		wait_reads();
	endtask

	task automatic random_reads(input int count);
		int issued;
		int burst;
		buf_addr_t a;
		issued = 0;
		while (issued < count) begin
			burst = $urandom_range(1, 6);
			for (int i = 0; i < burst; i++) begin
				a = buf_addr_t'($urandom);
				issue_read(a, shadow[a], 1'b1);
				issued++;
			end
			end_reads();
			repeat ($urandom_range(0, 3)) next_cycle();
		end
		wait_reads();
	endtask

	task automatic start_test();
		test_err_base = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_err_base) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name, errors - test_err_base);
		end
	endtask

	initial begin
		bitslip_t slip;
		int n;
		void'($urandom(39760));
		k = '0;
		lane0 = '0;
		lane1 = 8'h5a;
		lane2 = 8'hff;
		lane3 = 8'h33;
		bitslip = '0;
		capture_enable = 1'b0;
		rd_en = 1'b0;
		rd_addr = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rd_pending = 1'b0;
		last_data = '0;

		start_test();
		wait_signal("rst_n", 1'b1, 20);
		next_cycle();
		check_bit("capture_busy", capture_busy, 1'b0);
		check_bit("capture_done", capture_done, 1'b0);
		check_bit("rd_valid", rd_valid, 1'b0);
		finish_test("reset state");

		start_test();
		run_capture('0);
		check_buffer('0);
		next_cycle();
		capture_enable = 1'b0;
		wait_signal("capture_done", 1'b0, 20);
		finish_test("capture with bitslip 0");

		start_test();
		slip = bitslip_t'($urandom_range(1, LANE_BITS - 1));
		run_capture(slip);
		check_buffer(slip);
		finish_test($sformatf("capture with bitslip %0d", slip));

		// enable stays high, the buffer must not be refilled
		start_test();
		repeat (300) next_cycle();
		check_bit("capture_done", capture_done, 1'b1);
		check_bit("capture_busy", capture_busy, 1'b0);
		random_reads(32);
		capture_enable = 1'b0;
		wait_signal("capture_done", 1'b0, 20);
		finish_test("hold in done and reread");

		start_test();
		random_reads(64);
		finish_test("random reads");

		start_test();
		next_cycle();
		capture_enable = 1'b1;
		wait_signal("capture_busy", 1'b1, 20);
		repeat (100) next_cycle();
		capture_enable = 1'b0;
		wait_signal("capture_busy", 1'b0, 20);
		for (n = 0; n < 20; n++) begin
			check_bit("capture_done", capture_done, 1'b0);
			next_cycle();
		end
		finish_test("aborted capture");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- filelist.f
adc_capture_pkg.sv
lane_decoder.sv
capture_sequencer.sv
sample_buffer.sv
adc_capture_top.sv
tb_clock_gen.sv
tb_adc_capture.sv
